//--- hdl/frame_timer.sv
// Frame timer
// Pixel and scanline counters with vblank entry and exit events
`timescale 1ns/1ps
`include "ppu_settings.svh"

module frame_timer (
	input  logic                    clk,
	input  logic                    reset,
	input  ppu_pkg::sys_type_e      sys_type,
	output logic [8:0]              scanline,
	output logic [8:0]              cycle,
	output ppu_pkg::frame_events_t  events
);

	logic [8:0] vblank_start; // First vblank line for this system
	logic [8:0] vblank_end;   // Line after which the pre-render line follows
	logic       end_of_line;

	// Dendy enters vblank late, PAL and Dendy leave it late
	always_comb begin
		case (sys_type)
			ppu_pkg::sys_pal: begin
				vblank_start = 9'(`PPU_VBLANK_START_NTSC);
				vblank_end   = 9'(`PPU_VBLANK_END_PAL);
			end
			ppu_pkg::sys_dendy: begin
				vblank_start = 9'(`PPU_VBLANK_START_DENDY);
				vblank_end   = 9'(`PPU_VBLANK_END_PAL);
			end
			default: begin // NTSC and Vs.
				vblank_start = 9'(`PPU_VBLANK_START_NTSC);
				vblank_end   = 9'(`PPU_VBLANK_END_NTSC);
			end
		endcase
	end

	assign end_of_line = (cycle == 9'(`PPU_CYCLES_PER_LINE - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			cycle    <= '0;
			scanline <= '0;
		end else begin
			cycle <= end_of_line ? 9'd0 : cycle + 9'd1;
			if (end_of_line) begin
				if (scanline == vblank_end)
					scanline <= 9'(`PPU_PRE_RENDER_LINE); // Jump to line -1
				else if (scanline == 9'(`PPU_PRE_RENDER_LINE))
					scanline <= 9'd0;
				else
					scanline <= scanline + 9'd1;
			end
		end
	end

	// Flag logic sees these at pixel 0, so the flag reads set from pixel 1
	assign events.entering_vblank = (cycle == 9'd0) && (scanline == vblank_start);
	assign events.exiting_vblank  = (cycle == 9'd0) && (scanline == 9'(`PPU_PRE_RENDER_LINE));

endmodule

//--- hdl/palette_ram.sv
// Palette RAM
// 32 colour entries with backdrop mirroring and grayscale output
`timescale 1ns/1ps
`include "ppu_settings.svh"

module palette_ram (
	input  logic       clk,
	input  logic [4:0] index,
	input  logic       write,
	input  logic [5:0] wdata,
	input  logic       grayscale,
	output logic [5:0] color
);

	logic [5:0] mem [`PPU_PALETTE_DEPTH];
	logic [4:0] addr;
	logic [5:0] raw;

	// Entries 10/14/18/1C share storage with 00/04/08/0C
	assign addr = (index[1:0] == 2'b00) ? {1'b0, index[3:0]} : index;
	assign raw  = mem[addr];

	always_ff @(posedge clk) begin
		if (write)
			mem[addr] <= wdata;
	end

	assign color = grayscale ? {raw[5:4], 4'b0000} : raw; // Keep luma only

endmodule

//--- hdl/ppu_pkg.sv
// Picture processor types
// CPU bus, decoded strobes, register fields and the VRAM address views
package ppu_pkg;

	typedef enum logic [1:0] {
		sys_ntsc  = 2'd0,
		sys_pal   = 2'd1,
		sys_dendy = 2'd2,
		sys_vs    = 2'd3
	} sys_type_e;

	// CPU register index, $2000..$2007
	typedef enum logic [2:0] {
		reg_ctrl     = 3'd0,
		reg_mask     = 3'd1,
		reg_status   = 3'd2,
		reg_oam_addr = 3'd3, // Ignored
		reg_oam_data = 3'd4, // Ignored
		reg_scroll   = 3'd5,
		reg_addr     = 3'd6,
		reg_data     = 3'd7
	} reg_addr_e;

	typedef struct packed {
		logic      read;
		logic      write;
		reg_addr_e ain;
		logic [7:0] din;
	} cpu_bus_t;

	// One clock wide, decoded once in reg_file
	typedef struct packed {
		logic ctrl_write;
		logic scroll_write;
		logic addr_write;
		logic data_read;
		logic data_write;
		logic status_read;
	} reg_strobe_t;

	typedef struct packed {
		logic       vbl_enable;   // $2000 bit 7
		logic       increment_32; // $2000 bit 2
		logic [1:0] nametable;    // $2000 bits 1..0
	} ctrl_t;

	typedef struct packed {
		logic show_sprites;    // $2001 bit 4
		logic show_background; // $2001 bit 3
		logic grayscale;       // $2001 bit 0
	} mask_t;

	typedef struct packed {
		logic [2:0] fine_y;
		logic [1:0] nametable;
		logic [4:0] coarse_y;
		logic [4:0] coarse_x;
	} scroll_fields_t;

	// Scroll writes see fields, $2006/$2007 see a flat address
	typedef union packed {
		scroll_fields_t f;
		logic [14:0]    flat;
	} vram_addr_u;

	typedef struct packed {
		logic entering_vblank;
		logic exiting_vblank;
	} frame_events_t;

endpackage

//--- hdl/ppu_top.sv
// Picture processor register and timing core
// Frame timer, CPU registers, scroll/address pair, data port and palette
`timescale 1ns/1ps

module ppu_top (
	input  logic                clk,
	input  logic                reset,
	input  ppu_pkg::sys_type_e  sys_type,
	input  ppu_pkg::cpu_bus_t   cpu,      // Held for one clock per access
	input  logic [7:0]          vram_din,
	output logic [7:0]          dout,
	output logic                nmi,
	output logic [13:0]         vram_a,
	output logic                vram_r,
	output logic                vram_w,
	output logic [7:0]          vram_dout,
	output logic [5:0]          color,
	output logic [8:0]          scanline,
	output logic [8:0]          cycle
);

	ppu_pkg::frame_events_t events;
	ppu_pkg::reg_strobe_t   strobes;
	ppu_pkg::ctrl_t         ctrl;
	ppu_pkg::mask_t         mask;
	ppu_pkg::vram_addr_u    v;
	logic [7:0]             read_buffer;
	logic                   palette_hit;
	logic                   palette_write;
	logic [4:0]             palette_index;

	frame_timer u_frame_timer (
		.clk(clk), .reset(reset), .sys_type(sys_type),
		.scanline(scanline), .cycle(cycle), .events(events)
	);

	reg_file u_reg_file (
		.clk(clk), .reset(reset), .cpu(cpu), .events(events),
		.read_buffer(read_buffer),
		.palette_byte(color), // Palette reads return the displayed colour
		.palette_hit(palette_hit),
		.strobes(strobes), .ctrl(ctrl), .mask(mask), .nmi(nmi), .dout(dout)
	);

	scroll_regs u_scroll_regs (
		.clk(clk), .reset(reset), .din(cpu.din), .strobes(strobes), .ctrl(ctrl), .v(v)
	);

	ppudata_port u_ppudata_port (
		.clk(clk), .reset(reset), .strobes(strobes), .din(cpu.din), .v(v),
		.vram_din(vram_din), .vram_a(vram_a), .vram_r(vram_r), .vram_w(vram_w),
		.vram_dout(vram_dout), .read_buffer(read_buffer), .palette_hit(palette_hit),
		.palette_write(palette_write), .palette_index(palette_index)
	);

	palette_ram u_palette_ram (
		.clk(clk), .index(palette_index), .write(palette_write),
		.wdata(cpu.din[5:0]), // Top two bits are not stored
		.grayscale(mask.grayscale), .color(color)
	);

endmodule

//--- hdl/ppudata_port.sv
// $2007 data port
// Routes accesses to VRAM or palette and keeps the buffered read byte
`timescale 1ns/1ps

module ppudata_port (
	input  logic                  clk,
	input  logic                  reset,
	input  ppu_pkg::reg_strobe_t  strobes,
	input  logic [7:0]            din,
	input  ppu_pkg::vram_addr_u   v,
	input  logic [7:0]            vram_din,
	output logic [13:0]           vram_a,
	output logic                  vram_r,
	output logic                  vram_w,
	output logic [7:0]            vram_dout,
	output logic [7:0]            read_buffer,
	output logic                  palette_hit,
	output logic                  palette_write,
	output logic [4:0]            palette_index
);

	logic read_pending; // VRAM answers one clock after vram_r

	// 3F00..3FFF, bit 14 is not on the bus
	assign palette_hit = (v.flat[13:8] == 6'h3F);

	assign vram_a    = v.flat[13:0];
	assign vram_dout = din;
	assign vram_r    = strobes.data_read && !palette_hit;
	assign vram_w    = strobes.data_write && !palette_hit;

	assign palette_write = strobes.data_write && palette_hit;
	// Backdrop entry shows on color outside palette access
	assign palette_index = palette_hit ? v.flat[4:0] : 5'd0;

	always_ff @(posedge clk) begin
		if (reset) begin
			read_pending <= 1'b0;
			read_buffer  <= '0;
		end else begin
			read_pending <= vram_r;
			if (read_pending)
				read_buffer <= vram_din; // Seen by the next $2007 read
		end
	end

endmodule

//--- hdl/reg_file.sv
// CPU register file
// Decodes accesses, holds $2000/$2001, the vblank flag and the dout latch
`timescale 1ns/1ps

module reg_file (
	input  logic                    clk,
	input  logic                    reset,
	input  ppu_pkg::cpu_bus_t       cpu,
	input  ppu_pkg::frame_events_t  events,
	input  logic [7:0]              read_buffer,
	input  logic [5:0]              palette_byte,
	input  logic                    palette_hit,
	output ppu_pkg::reg_strobe_t    strobes,
	output ppu_pkg::ctrl_t          ctrl,
	output ppu_pkg::mask_t          mask,
	output logic                    nmi,
	output logic [7:0]              dout
);

	logic mask_write; // Only this block needs it
	logic vbl_flag;   // Set in vblank, cleared by exit or $2002 read

	// Single place where ain is decoded
	always_comb begin
		strobes.ctrl_write   = cpu.write && (cpu.ain == ppu_pkg::reg_ctrl);
		strobes.scroll_write = cpu.write && (cpu.ain == ppu_pkg::reg_scroll);
		strobes.addr_write   = cpu.write && (cpu.ain == ppu_pkg::reg_addr);
		strobes.data_write   = cpu.write && (cpu.ain == ppu_pkg::reg_data);
		strobes.data_read    = cpu.read && (cpu.ain == ppu_pkg::reg_data);
		strobes.status_read  = cpu.read && (cpu.ain == ppu_pkg::reg_status);
		mask_write           = cpu.write && (cpu.ain == ppu_pkg::reg_mask);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl     <= '0;
			mask     <= '0;
			vbl_flag <= 1'b0;
			dout     <= '0;
		end else begin
			if (strobes.ctrl_write) begin
				ctrl.vbl_enable   <= cpu.din[7];
				ctrl.increment_32 <= cpu.din[2];
				ctrl.nametable    <= cpu.din[1:0];
			end
			if (mask_write) begin
				mask.show_sprites    <= cpu.din[4];
				mask.show_background <= cpu.din[3];
				mask.grayscale       <= cpu.din[0];
			end

			// Status read wins over a same-cycle vblank entry
			if (strobes.status_read || events.exiting_vblank)
				vbl_flag <= 1'b0;
			else if (events.entering_vblank)
				vbl_flag <= 1'b1;

			if (cpu.write)
				dout <= cpu.din; // Any write lands on the bus
			else if (strobes.status_read)
				dout <= {vbl_flag, 2'b00, dout[4:0]}; // No sprite flags, low bits stay
			else if (strobes.data_read)
				dout <= palette_hit ? {2'b00, palette_byte} : read_buffer;
		end
	end

	assign nmi = vbl_flag && ctrl.vbl_enable;

endmodule

//--- hdl/scroll_regs.sv
// Scroll and address registers
// Temporary address t, current address v and the shared write toggle
`timescale 1ns/1ps

module scroll_regs (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [7:0]            din,
	input  ppu_pkg::reg_strobe_t  strobes,
	input  ppu_pkg::ctrl_t        ctrl,
	output ppu_pkg::vram_addr_u   v
);

	ppu_pkg::vram_addr_u t;      // Loaded by $2000, $2005 and $2006
	logic                toggle; // 0 first write, 1 second write
	logic [14:0]         step;

	assign step = ctrl.increment_32 ? 15'd32 : 15'd1; // Across or down

	always_ff @(posedge clk) begin
		if (reset) begin
			t      <= '0;
			v      <= '0;
			toggle <= 1'b0;
		end else if (strobes.ctrl_write) begin
			t.f.nametable <= din[1:0];
		end else if (strobes.scroll_write) begin
			if (!toggle)
				t.f.coarse_x <= din[7:3];
			else begin
				t.f.coarse_y <= din[7:3];
				t.f.fine_y   <= din[2:0];
			end
			toggle <= !toggle;
		end else if (strobes.addr_write) begin
			if (!toggle) begin
				t.flat[14]   <= 1'b0; // Only six address bits in the high byte
				t.flat[13:8] <= din[5:0];
			end else begin
				t.flat[7:0] <= din;
				v.flat      <= {t.flat[14:8], din}; // Second write commits
			end
			toggle <= !toggle;
		end else if (strobes.status_read) begin
			toggle <= 1'b0;
		end else if (strobes.data_read || strobes.data_write) begin
			v.flat <= v.flat + step;
		end
	end

endmodule

//--- include/ppu_settings.svh
// Picture processor settings
// Frame geometry, vblank line numbers and palette size
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// Pixels per scanline, one pixel per clk
`define PPU_CYCLES_PER_LINE 341

// First vblank line, NTSC/Vs. and PAL
`define PPU_VBLANK_START_NTSC 241
// Dendy enters vblank fifty lines later
`define PPU_VBLANK_START_DENDY 291

// Last vblank line before the pre-render line
`define PPU_VBLANK_END_NTSC 260
`define PPU_VBLANK_END_PAL 310

// Pre-render line, the -1 line seen as 9 bits
`define PPU_PRE_RENDER_LINE 511

// Palette entries
`define PPU_PALETTE_DEPTH 32

`endif

//--- run.sh
#!/bin/sh
# Build and run the picture processor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module ppu_tb -o ppu_sim

# The simulator exits non-zero on $fatal, the log decides the result
./obj_dir/ppu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "Simulation reported failures"
	exit 1
fi
grep -q "ALL CHECKS PASSED" sim.log

//--- src.f
+incdir+include
hdl/ppu_pkg.sv
hdl/frame_timer.sv
hdl/reg_file.sv
hdl/scroll_regs.sv
hdl/ppudata_port.sv
hdl/palette_ram.sv
hdl/ppu_top.sv
test/ppu_assert.sv
test/ppu_tb.sv

//--- test/ppu_assert.sv
// Picture processor bus assertions
// Bound to the top level, watches the VRAM strobes and the NMI output
`timescale 1ns/1ps

module ppu_assert (
	input logic              clk,
	input logic              reset,
	input ppu_pkg::cpu_bus_t cpu,
	input logic              nmi,
	input logic              vram_r,
	input logic              vram_w
);

	logic last_vbl_enable; // Bit 7 of the last $2000 write seen on the bus

	always_ff @(posedge clk) begin
		if (reset)
			last_vbl_enable <= 1'b0;
		else if (cpu.write && cpu.ain == ppu_pkg::reg_ctrl)
			last_vbl_enable <= cpu.din[7];
	end

	// One VRAM access at a time
	vram_one_dir: assert property (@(posedge clk) disable iff (reset)
		!(vram_r && vram_w))
		else $error("vram_r and vram_w high together");

	write_from_data_port: assert property (@(posedge clk) disable iff (reset)
		$rose(vram_w) |-> (cpu.write && cpu.ain == ppu_pkg::reg_data))
		else $error("vram_w rose without a data port write");

	nmi_needs_enable: assert property (@(posedge clk) disable iff (reset)
		nmi |-> last_vbl_enable) // Gated by $2000 bit 7
		else $error("nmi high with vbl_enable clear");

endmodule

bind ppu_top ppu_assert assert_i (
	.clk(clk), .reset(reset), .cpu(cpu), .nmi(nmi),
	.vram_r(vram_r), .vram_w(vram_w)
);

//--- test/ppu_tb.sv
// Picture processor testbench
// Frame length, status, $2005/$2006/$2007 traffic and palette checks
`timescale 1ns/1ps
`include "ppu_settings.svh"

module ppu_tb;

	logic                clk = 1'b0;
	logic                reset;
	ppu_pkg::sys_type_e  sys_type;
	ppu_pkg::cpu_bus_t   cpu;
	logic [7:0]          vram_din = 8'h00;
	logic [7:0]          dout;
	logic                nmi;
	logic [13:0]         vram_a;
	logic                vram_r;
	logic                vram_w;
	logic [7:0]          vram_dout;
	logic [5:0]          color;
	logic [8:0]          scanline;
	logic [8:0]          cycle;

	logic [7:0]     vram_mem [16384];           // VRAM model
	logic [5:0]     pal_ref [`PPU_PALETTE_DEPTH]; // Expected palette entries
	logic [13:0]    exp_addr [$];               // Expected vram_w pulses
	logic [7:0]     exp_data [$];
	logic [7:0]     exp_buffer;                 // Expected read buffer
	ppu_pkg::ctrl_t ctrl_ref;
	bit             gray_ref;

	localparam ppu_pkg::cpu_bus_t idle_bus =
		'{read: 1'b0, write: 1'b0, ain: ppu_pkg::reg_ctrl, din: 8'h00};

	ppu_top dut_i (.*);

	always #10 clk = ~clk; // 20 ns period

	// VRAM answers a read on the next clock
	always @(posedge clk) begin
		if (vram_r)
			vram_din <= vram_mem[vram_a];
		if (vram_w)
			vram_mem[vram_a] = vram_dout;
	end

	function automatic int ref_frame_clocks(input ppu_pkg::sys_type_e sys);
		int last_line;
		last_line = (sys == ppu_pkg::sys_pal || sys == ppu_pkg::sys_dendy) ?
			`PPU_VBLANK_END_PAL : `PPU_VBLANK_END_NTSC;
		return (last_line + 2) * `PPU_CYCLES_PER_LINE; // Lines 0..last plus pre-render
	endfunction

	function automatic logic [13:0] ref_vram_step(input ppu_pkg::ctrl_t c);
		return c.increment_32 ? 14'd32 : 14'd1;
	endfunction

	function automatic logic [4:0] ref_palette_index(input logic [13:0] addr);
		logic [4:0] idx;
		idx = addr[4:0];
		if (idx[1:0] == 2'b00)
			idx[4] = 1'b0; // Sprite backdrops fold onto background ones
		return idx;
	endfunction

	function automatic logic [5:0] ref_color(input logic [5:0] entry, input bit gray);
		return gray ? (entry & 6'h30) : entry;
	endfunction

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("CHECKS FAILED");
		$fatal(1, "Run stopped at %0t", $time);
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp)
			stop_run($sformatf("ERR %0t %s: got %02h, expected %02h", $time, what, got, exp));
	endtask

	task automatic check_addr(input logic [13:0] got, input logic [13:0] exp, input string what);
		if (got !== exp)
			stop_run($sformatf("ERR %0t %s: got %04h, expected %04h", $time, what, got, exp));
	endtask

	task automatic check_color(input logic [5:0] got, input logic [5:0] exp, input string what);
		if (got !== exp)
			stop_run($sformatf("ERR %0t %s: got %02h, expected %02h", $time, what, got, exp));
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
			stop_run($sformatf("ERR %0t %s: got %0d, expected %0d", $time, what, got, exp));
	endtask

	// Compares each VRAM write pulse with the next expected one
	always @(negedge clk) begin
		if (!reset && vram_w) begin
			if (exp_addr.size() == 0)
				stop_run("A VRAM write appeared when none was expected");
			else begin
				check_addr(vram_a, exp_addr.pop_front(), "vram_a on write");
				check_byte(vram_dout, exp_data.pop_front(), "vram_dout on write");
			end
		end
	end

	task automatic cpu_write(input ppu_pkg::reg_addr_e sel, input logic [7:0] data);
		@(posedge clk);
		cpu <= '{read: 1'b0, write: 1'b1, ain: sel, din: data};
		@(posedge clk);
		cpu <= idle_bus; // One clock per access
	endtask

	task automatic cpu_read(input ppu_pkg::reg_addr_e sel, output logic [7:0] data);
		@(posedge clk);
		cpu <= '{read: 1'b1, write: 1'b0, ain: sel, din: 8'h00};
		@(posedge clk);
		cpu <= idle_bus;
		@(negedge clk);
		data = dout; // Latched at the read edge
	endtask

	task automatic set_addr(input logic [13:0] addr);
		logic [7:0] status_byte;
		cpu_read(ppu_pkg::reg_status, status_byte); // Clears the write toggle
		cpu_write(ppu_pkg::reg_addr, {2'b00, addr[13:8]});
		cpu_write(ppu_pkg::reg_addr, addr[7:0]);
	endtask

	task automatic wait_nmi_rise(output int clocks);
		logic last;
		logic rose;
		clocks = 0;
		last = nmi;
		do begin
			@(negedge clk);
			clocks++;
			if (clocks > 2 * ref_frame_clocks(ppu_pkg::sys_pal))
				stop_run("Timed out waiting for a rising edge on nmi");
			rose = nmi && !last;
			last = nmi;
		end while (!rose);
	endtask

	initial begin
		logic [7:0]  data;
		logic [13:0] base;
		int          clocks;
		void'($urandom(32'h5ea2_ade6));
		reset = 1'b1;
		sys_type = ppu_pkg::sys_ntsc;
		cpu = idle_bus;
		for (int i = 0; i < 16384; i++)
			vram_mem[i] = 8'(i) ^ 8'(i >> 5) ^ 8'(i >> 8); // Every address bit counts
		exp_buffer = 8'h00; // Buffer comes out of reset cleared
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		// NMI position and NTSC frame length
		cpu_write(ppu_pkg::reg_ctrl, 8'h80);
		wait_nmi_rise(clocks);
		check_count(int'(scanline), `PPU_VBLANK_START_NTSC, "scanline at first NMI");
		check_count(int'(cycle), 1, "cycle at first NMI");
		wait_nmi_rise(clocks);
		check_count(clocks, ref_frame_clocks(ppu_pkg::sys_ntsc), "NTSC frame clocks");

		// Status reads inside vblank
		cpu_read(ppu_pkg::reg_status, data);
		check_byte(data & 8'he0, 8'h80, "first status read");
		cpu_read(ppu_pkg::reg_status, data);
		check_byte(data & 8'he0, 8'h00, "second status read");
		check_count(int'(nmi), 0, "nmi after status reads");

		@(posedge clk);
		sys_type <= ppu_pkg::sys_pal;
		wait_nmi_rise(clocks); // First PAL vblank
		wait_nmi_rise(clocks);
		check_count(clocks, ref_frame_clocks(ppu_pkg::sys_pal), "PAL frame clocks");

		// Data port writes, step 1 then step 32
		for (int pass = 0; pass < 2; pass++) begin
			ctrl_ref = '0;
			ctrl_ref.increment_32 = (pass == 1);
			cpu_write(ppu_pkg::reg_ctrl, {5'd0, ctrl_ref.increment_32, 2'b00});
			base = (pass == 0) ? 14'h2100 : 14'h2400;
			cpu_write(ppu_pkg::reg_scroll, 8'h5d); // Leaves the toggle set
			set_addr(base);
			for (int k = 0; k < 4; k++) begin
				data = 8'($urandom);
				exp_addr.push_back(base + 14'(k) * ref_vram_step(ctrl_ref));
				exp_data.push_back(data);
				cpu_write(ppu_pkg::reg_data, data);
			end
		end

		// Buffered reads over written and pattern bytes
		ctrl_ref = '0;
		cpu_write(ppu_pkg::reg_ctrl, 8'h00);
		set_addr(14'h2102);
		for (int k = 0; k < 6; k++) begin
			cpu_read(ppu_pkg::reg_data, data);
			check_byte(data, exp_buffer, "buffered data read");
			exp_buffer = vram_mem[14'h2102 + 14'(k)];
		end

		// Palette fill, then read back plain and in grayscale
		set_addr(14'h3F00);
		for (int k = 0; k < `PPU_PALETTE_DEPTH; k++) begin
			data = 8'($urandom);
			pal_ref[ref_palette_index(14'h3F00 + 14'(k))] = data[5:0];
			cpu_write(ppu_pkg::reg_data, data);
		end
		for (int g = 0; g < 2; g++) begin
			gray_ref = (g == 1);
			cpu_write(ppu_pkg::reg_mask, {7'd0, gray_ref});
			set_addr(14'h3F00);
			for (int k = 0; k < `PPU_PALETTE_DEPTH; k++) begin
				@(negedge clk);
				check_color(color, ref_color(pal_ref[ref_palette_index(14'h3F00 + 14'(k))],
					gray_ref), "color at palette address");
				cpu_read(ppu_pkg::reg_data, data);
				check_byte(data, {2'b00, ref_color(pal_ref[ref_palette_index(14'h3F00 +
					14'(k))], gray_ref)}, "palette read");
			end
			set_addr(14'h2015); // Leave the palette, color shows the backdrop
			@(negedge clk);
			check_color(color, ref_color(pal_ref[0], gray_ref), "backdrop color");
		end

		if (exp_addr.size() != 0)
			stop_run("Some expected VRAM writes never appeared");
		else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule
